// ==== Makefile ====
# Verilator build for the Space Invaders testbench

VERILATOR ?= verilator
TOP ?= tb_space_invaders
ALIEN_COUNT ?= 4
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FLIST ?= flist.f
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -GALIEN_COUNT=$(ALIEN_COUNT) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
src/invaders_pkg.sv
src/frame_timer.sv
src/sprite_painter.sv
src/alien_fleet.sv
src/cannon.sv
src/score_keeper.sv
src/game_sequencer.sv
src/space_invaders.sv
testbench/tb_space_invaders.sv

// ==== src/alien_fleet.sv ====
`timescale 1ns/100ps
`default_nettype none

module alien_fleet #(
	parameter int ALIEN_COUNT = 4
) (
	input wire CLOCK_50,
	input wire reset,
	input wire new_game,
	input wire alien_step,
	input wire [1:0] step_index,
	input wire kill,
	input wire invaders_pkg::cannon_state_t shot,
	output invaders_pkg::coord_x_t [invaders_pkg::max_aliens-1:0] alien_x,
	output invaders_pkg::coord_y_t [invaders_pkg::max_aliens-1:0] alien_y,
	output logic [invaders_pkg::max_aliens-1:0] alive,
	output logic hit,
	output logic [1:0] hit_index,
	output logic breach
);

	logic [invaders_pkg::max_aliens-1:0] moving_right;
	logic [invaders_pkg::max_aliens-1:0] shot_inside;

	// shot point inside a live sprite box
	always_comb begin
		for (int i = 0; i < invaders_pkg::max_aliens; i++) begin
			shot_inside[i] = alive[i] && shot.fired
				&& shot.shot_x >= alien_x[i]
				&& int'(shot.shot_x) <= int'(alien_x[i]) + invaders_pkg::sprite_w - 1
				&& shot.shot_y >= alien_y[i]
				&& int'(shot.shot_y) <= int'(alien_y[i]) + invaders_pkg::sprite_h - 1;
		end
	end

	// lowest index wins
	always_comb begin
		hit = |shot_inside;
		hit_index = '0;
		for (int i = invaders_pkg::max_aliens - 1; i >= 0; i--) begin
			if (shot_inside[i])
				hit_index = 2'(i);
		end
	end

	// bottom of a live alien reaches the cannon row
	always_comb begin
		breach = 1'b0;
		for (int i = 0; i < invaders_pkg::max_aliens; i++) begin
			if (alive[i] && int'(alien_y[i]) + invaders_pkg::sprite_h - 1
					>= int'(invaders_pkg::cannon_y))
				breach = 1'b1;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset || new_game) begin
			for (int i = 0; i < invaders_pkg::max_aliens; i++) begin
				alien_x[i] <= invaders_pkg::alien_start_x[i];
				alien_y[i] <= '0;
				moving_right[i] <= 1'b1;
				alive[i] <= (i < ALIEN_COUNT);
			end
		end else begin
			if (alien_step) begin
				// at an edge: turn, drop a row, then step the new way
				if (alien_x[step_index] >= invaders_pkg::alien_max_x) begin
					moving_right[step_index] <= 1'b0;
					alien_x[step_index] <= invaders_pkg::alien_max_x - 8'd1;
					alien_y[step_index] <= alien_y[step_index] + 7'd8;
				end else if (alien_x[step_index] == '0 && alien_y[step_index] != '0) begin
					moving_right[step_index] <= 1'b1;
					alien_x[step_index] <= 8'd1;
					alien_y[step_index] <= alien_y[step_index] + 7'd8;
				end else if (moving_right[step_index]) begin
					alien_x[step_index] <= alien_x[step_index] + 8'd1;
				end else begin
					alien_x[step_index] <= alien_x[step_index] - 8'd1;
				end
			end
			if (kill)
				alive[hit_index] <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== src/cannon.sv ====
`timescale 1ns/100ps
`default_nettype none

module cannon (
	input wire CLOCK_50,
	input wire reset,
	input wire new_game,
	input wire invaders_pkg::buttons_t buttons,
	input wire cannon_step,
	input wire shot_step,
	input wire reload,
	output invaders_pkg::cannon_state_t state
);

	invaders_pkg::coord_x_t move_x;

	// one pixel per frame, held inside 0 to alien_max_x
	always_comb begin
		move_x = state.cannon_x;
		if (buttons.right && !buttons.left && state.cannon_x < invaders_pkg::alien_max_x)
			move_x = state.cannon_x + 8'd1;
		else if (buttons.left && !buttons.right && state.cannon_x != '0)
			move_x = state.cannon_x - 8'd1;
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset || new_game) begin
			state.cannon_x <= invaders_pkg::cannon_start_x;
			state.shot_x <= invaders_pkg::cannon_start_x + 8'd4;
			state.shot_y <= invaders_pkg::line_y;
			state.fired <= 1'b0;
		end else if (cannon_step) begin
			state.cannon_x <= move_x;
			// resting shot rides along with the cannon
			if (!state.fired)
				state.shot_x <= move_x + 8'd4;
		end else if (reload || (shot_step && state.shot_y == '0)) begin
			state.shot_x <= state.cannon_x + 8'd4;
			state.shot_y <= invaders_pkg::line_y;
			state.fired <= 1'b0;
		end else if (shot_step && (state.fired || buttons.fire)) begin
			// launch frame already rises one row
			state.shot_y <= state.shot_y - 7'd1;
			state.fired <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/frame_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_timer #(
	parameter int FRAME_TICKS = 833333
) (
	input wire CLOCK_50,
	input wire reset,
	output logic frame_tick
);

	localparam int count_w = $clog2(FRAME_TICKS);

	logic [count_w-1:0] count;

	// tick on the last count of each period
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			count <= '0;
			frame_tick <= 1'b0;
		end else if (count == count_w'(FRAME_TICKS - 1)) begin
			count <= '0;
			frame_tick <= 1'b1;
		end else begin
			count <= count + 1'b1;
			frame_tick <= 1'b0;
		end
	end

	tick_single_cycle: assert property (@(posedge CLOCK_50) disable iff (reset)
		frame_tick |=> !frame_tick);

endmodule

`default_nettype wire

// ==== src/game_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module game_sequencer #(
	parameter int ALIEN_COUNT = 4
) (
	input wire CLOCK_50,
	input wire reset,
	input wire invaders_pkg::buttons_t buttons,
	input wire frame_tick,
	input wire paint_done,
	output logic paint_start,
	output invaders_pkg::paint_req_t paint_req,
	output logic cannon_step,
	output logic shot_step,
	output logic reload,
	output logic alien_step,
	output logic [1:0] step_index,
	output logic kill,
	input wire invaders_pkg::cannon_state_t cannon_state,
	input wire invaders_pkg::coord_x_t [invaders_pkg::max_aliens-1:0] alien_x,
	input wire invaders_pkg::coord_y_t [invaders_pkg::max_aliens-1:0] alien_y,
	input wire [invaders_pkg::max_aliens-1:0] alive,
	input wire hit,
	input wire [1:0] hit_index,
	input wire breach,
	output logic new_game,
	output logic lose,
	output logic win
);

	// frame loop states sit between s_can_erase and s_kill
	typedef enum logic [4:0] {
		s_new_screen, s_new_line, s_new_cannon, s_new_shot, s_new_alien,
		s_wait,
		s_can_erase, s_can_move, s_can_draw,
		s_alien_erase, s_alien_move, s_alien_draw,
		s_shot_erase, s_shot_move, s_shot_draw,
		s_test, s_kill_erase, s_kill,
		s_lose_fill, s_win_fill, s_hold
	} state_e;

	state_e state, state_next;
	logic [1:0] idx, idx_next;
	logic pending;
	logic want_paint;
	logic last_alien;

	assign last_alien = idx == 2'(ALIEN_COUNT - 1);
	assign step_index = idx;
	assign paint_start = want_paint && !pending;

	always_comb begin
		state_next = state;
		idx_next = idx;
		want_paint = 1'b0;
		paint_req.kind = invaders_pkg::paint_sprite;
		paint_req.x = alien_x[idx];
		paint_req.y = alien_y[idx];
		paint_req.colour = invaders_pkg::colour_black;
		cannon_step = 1'b0;
		shot_step = 1'b0;
		reload = 1'b0;
		alien_step = 1'b0;
		kill = 1'b0;
		new_game = 1'b0;
		lose = 1'b0;
		win = 1'b0;
		case (state)
			s_new_screen, s_lose_fill, s_win_fill: begin
				want_paint = 1'b1;
				paint_req.kind = invaders_pkg::paint_screen;
				paint_req.x = '0;
				paint_req.y = '0;
				if (state == s_lose_fill)
					paint_req.colour = invaders_pkg::colour_red;
				else if (state == s_win_fill)
					paint_req.colour = invaders_pkg::colour_green;
				if (paint_done)
					state_next = (state == s_new_screen) ? s_new_line : s_hold;
			end
			s_new_line: begin
				want_paint = 1'b1;
				paint_req.kind = invaders_pkg::paint_line;
				paint_req.x = '0;
				paint_req.y = invaders_pkg::line_y;
				paint_req.colour = invaders_pkg::colour_cyan;
				if (paint_done)
					state_next = s_new_cannon;
			end
			s_new_cannon, s_can_erase, s_can_draw: begin
				want_paint = 1'b1;
				paint_req.x = cannon_state.cannon_x;
				paint_req.y = invaders_pkg::cannon_y;
				if (state != s_can_erase)
					paint_req.colour = invaders_pkg::colour_white;
				if (paint_done) begin
					idx_next = '0;
					if (state == s_new_cannon)
						state_next = s_new_shot;
					else if (state == s_can_erase)
						state_next = s_can_move;
					else
						state_next = s_alien_erase;
				end
			end
			s_new_shot, s_shot_erase, s_shot_draw: begin
				want_paint = 1'b1;
				paint_req.kind = invaders_pkg::paint_dot;
				paint_req.x = cannon_state.shot_x;
				paint_req.y = cannon_state.shot_y;
				// a resting shot sits on the end line, so erase it back to cyan
				if (state != s_shot_erase || cannon_state.shot_y == invaders_pkg::line_y)
					paint_req.colour = invaders_pkg::colour_cyan;
				if (paint_done) begin
					idx_next = '0;
					if (state == s_new_shot)
						state_next = s_new_alien;
					else if (state == s_shot_erase)
						state_next = s_shot_move;
					else
						state_next = s_test;
				end
			end
			s_new_alien, s_alien_erase, s_alien_draw: begin
				// dead aliens are skipped without a paint
				want_paint = alive[idx];
				if (state != s_alien_erase)
					paint_req.colour = invaders_pkg::colour_magenta;
				if (state == s_alien_erase && alive[idx]) begin
					if (paint_done)
						state_next = s_alien_move;
				end else if (!alive[idx] || paint_done) begin
					idx_next = idx + 2'd1;
					if (last_alien)
						state_next = (state == s_new_alien) ? s_wait : s_shot_erase;
					else if (state == s_alien_draw)
						state_next = s_alien_erase;
				end
			end
			s_wait: begin
				if (frame_tick)
					state_next = s_can_erase;
			end
			s_can_move: begin
				cannon_step = 1'b1;
				state_next = s_can_draw;
			end
			s_alien_move: begin
				alien_step = 1'b1;
				state_next = s_alien_draw;
			end
			s_shot_move: begin
				shot_step = 1'b1;
				state_next = s_shot_draw;
			end
			s_test: begin
				if (hit) begin
					state_next = s_kill_erase;
				end else if (breach) begin
					lose = 1'b1;
					state_next = s_lose_fill;
				end else if (alive == '0) begin
					win = 1'b1;
					state_next = s_win_fill;
				end else begin
					state_next = s_wait;
				end
			end
			s_kill_erase: begin
				want_paint = 1'b1;
				paint_req.x = alien_x[hit_index];
				paint_req.y = alien_y[hit_index];
				if (paint_done)
					state_next = s_kill;
			end
			s_kill: begin
				kill = 1'b1;
				reload = 1'b1;
				state_next = s_test;
			end
			s_hold: begin
				if (buttons.restart) begin
					new_game = 1'b1;
					idx_next = '0;
					state_next = s_new_screen;
				end
			end
			default: state_next = s_new_screen;
		endcase
	end

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state <= s_new_screen;
			idx <= '0;
			pending <= 1'b0;
		end else begin
			state <= state_next;
			idx <= idx_next;
			if (paint_start)
				pending <= 1'b1;
			else if (paint_done)
				pending <= 1'b0;
		end
	end

	tick_outside_frame: assert property (@(posedge CLOCK_50) disable iff (reset)
		frame_tick |-> !(state inside {[s_can_erase:s_kill]}));

endmodule

`default_nettype wire

// ==== src/invaders_pkg.sv ====
`default_nettype none

package invaders_pkg;

	// screen and sprite geometry
	localparam int screen_w = 160;
	localparam int screen_h = 120;
	localparam int sprite_w = 16;
	localparam int sprite_h = 8;
	localparam int max_aliens = 4;

	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;
	typedef logic [2:0] colour_t;

	// fixed rows, limits and start columns
	localparam coord_y_t cannon_y = 7'd110;
	localparam coord_y_t line_y = 7'd108;
	localparam coord_x_t cannon_start_x = 8'd76;
	localparam coord_x_t alien_max_x = 8'd144;
	localparam coord_x_t [max_aliens-1:0] alien_start_x = {8'd90, 8'd60, 8'd30, 8'd0};

	// rgb, one bit per channel
	localparam colour_t colour_black = 3'b000;
	localparam colour_t colour_red = 3'b100;
	localparam colour_t colour_green = 3'b010;
	localparam colour_t colour_cyan = 3'b011;
	localparam colour_t colour_magenta = 3'b101;
	localparam colour_t colour_white = 3'b111;

	typedef struct packed {
		logic plot;
		coord_x_t x;
		coord_y_t y;
		colour_t colour;
	} pixel_write_t;

	typedef struct packed {
		logic left;
		logic right;
		logic fire;
		logic restart;
	} buttons_t;

	typedef enum logic [1:0] {
		paint_screen,
		paint_line,
		paint_sprite,
		paint_dot
	} paint_kind_e;

	// origin of the run plus its colour
	typedef struct packed {
		paint_kind_e kind;
		coord_x_t x;
		coord_y_t y;
		colour_t colour;
	} paint_req_t;

	typedef struct packed {
		coord_x_t cannon_x;
		coord_x_t shot_x;
		coord_y_t shot_y;
		logic fired;
	} cannon_state_t;

endpackage

`default_nettype wire

// ==== src/score_keeper.sv ====
`timescale 1ns/100ps
`default_nettype none

module score_keeper (
	input wire CLOCK_50,
	input wire reset,
	input wire new_game,
	input wire kill,
	input wire lose,
	input wire win,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);

	logic [7:0] score;
	logic [7:0] high_score;
	logic [7:0] lowered;
	logic [7:0] score_mod;
	logic [7:0] high_mod;

	// active low, segment g in bit 6
	function automatic logic [6:0] seg7(input logic [3:0] digit);
		case (digit)
			4'd0: seg7 = 7'b1000000;
			4'd1: seg7 = 7'b1111001;
			4'd2: seg7 = 7'b0100100;
			4'd3: seg7 = 7'b0110000;
			4'd4: seg7 = 7'b0011001;
			4'd5: seg7 = 7'b0010010;
			4'd6: seg7 = 7'b0000010;
			4'd7: seg7 = 7'b1111000;
			4'd8: seg7 = 7'b0000000;
			4'd9: seg7 = 7'b0010000;
			default: seg7 = 7'b1111111;
		endcase
	endfunction

	// losing costs three points, never below zero
	assign lowered = (score >= 8'd3) ? score - 8'd3 : 8'd0;

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			score <= '0;
			high_score <= '0;
		end else if (new_game) begin
			score <= '0;
		end else if (kill) begin
			score <= score + 8'd1;
		end else if (lose) begin
			score <= lowered;
			if (lowered > high_score)
				high_score <= lowered;
		end else if (win && score > high_score) begin
			high_score <= score;
		end
	end

	assign score_mod = score % 8'd100;
	assign high_mod = high_score % 8'd100;

	assign hex0 = seg7(4'(score_mod % 8'd10));
	assign hex1 = seg7(4'(score_mod / 8'd10));
	assign hex4 = seg7(4'(high_mod % 8'd10));
	assign hex5 = seg7(4'(high_mod / 8'd10));

	high_score_monotonic: assert property (@(posedge CLOCK_50) disable iff (reset)
		1'b1 |=> high_score >= $past(high_score));

endmodule

`default_nettype wire

// ==== src/space_invaders.sv ====
`timescale 1ns/100ps
`default_nettype none

module space_invaders #(
	parameter int FRAME_TICKS = 833333,
	parameter int ALIEN_COUNT = 4
) (
	input wire CLOCK_50,
	input wire reset,
	input wire invaders_pkg::buttons_t buttons,
	output invaders_pkg::pixel_write_t pixel,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);

	logic frame_tick;
	logic paint_start;
	logic paint_done;
	invaders_pkg::paint_req_t paint_req;
	logic cannon_step;
	logic shot_step;
	logic reload;
	logic alien_step;
	logic [1:0] step_index;
	logic kill;
	logic new_game;
	logic lose;
	logic win;
	invaders_pkg::cannon_state_t cannon_state;
	invaders_pkg::coord_x_t [invaders_pkg::max_aliens-1:0] alien_x;
	invaders_pkg::coord_y_t [invaders_pkg::max_aliens-1:0] alien_y;
	logic [invaders_pkg::max_aliens-1:0] alive;
	logic hit;
	logic [1:0] hit_index;
	logic breach;

	frame_timer #(.FRAME_TICKS(FRAME_TICKS)) timer (
		.CLOCK_50(CLOCK_50), .reset(reset), .frame_tick(frame_tick)
	);

	sprite_painter painter (
		.CLOCK_50(CLOCK_50), .reset(reset), .paint_start(paint_start),
		.paint_req(paint_req), .paint_done(paint_done), .pixel(pixel)
	);

	alien_fleet #(.ALIEN_COUNT(ALIEN_COUNT)) fleet (
		.CLOCK_50(CLOCK_50), .reset(reset), .new_game(new_game),
		.alien_step(alien_step), .step_index(step_index), .kill(kill),
		.shot(cannon_state), .alien_x(alien_x), .alien_y(alien_y), .alive(alive),
		.hit(hit), .hit_index(hit_index), .breach(breach)
	);

	cannon player (
		.CLOCK_50(CLOCK_50), .reset(reset), .new_game(new_game), .buttons(buttons),
		.cannon_step(cannon_step), .shot_step(shot_step), .reload(reload),
		.state(cannon_state)
	);

	score_keeper scores (
		.CLOCK_50(CLOCK_50), .reset(reset), .new_game(new_game), .kill(kill),
		.lose(lose), .win(win), .hex0(hex0), .hex1(hex1), .hex4(hex4), .hex5(hex5)
	);

	game_sequencer #(.ALIEN_COUNT(ALIEN_COUNT)) sequencer (
		.CLOCK_50(CLOCK_50), .reset(reset), .buttons(buttons), .frame_tick(frame_tick),
		.paint_done(paint_done), .paint_start(paint_start), .paint_req(paint_req),
		.cannon_step(cannon_step), .shot_step(shot_step), .reload(reload),
		.alien_step(alien_step), .step_index(step_index), .kill(kill),
		.cannon_state(cannon_state), .alien_x(alien_x), .alien_y(alien_y),
		.alive(alive), .hit(hit), .hit_index(hit_index), .breach(breach),
		.new_game(new_game), .lose(lose), .win(win)
	);

endmodule

`default_nettype wire

// ==== src/sprite_painter.sv ====
`timescale 1ns/100ps
`default_nettype none

module sprite_painter (
	input wire CLOCK_50,
	input wire reset,
	input wire paint_start,
	input wire invaders_pkg::paint_req_t paint_req,
	output logic paint_done,
	output invaders_pkg::pixel_write_t pixel
);

	invaders_pkg::paint_req_t req;
	logic busy;
	invaders_pkg::coord_x_t off_x;
	invaders_pkg::coord_y_t off_y;
	invaders_pkg::coord_x_t last_x;
	invaders_pkg::coord_y_t last_y;

	// run size from the request kind
	always_comb begin
		case (req.kind)
			invaders_pkg::paint_screen: begin
				last_x = invaders_pkg::coord_x_t'(invaders_pkg::screen_w - 1);
				last_y = invaders_pkg::coord_y_t'(invaders_pkg::screen_h - 1);
			end
			invaders_pkg::paint_line: begin
				last_x = invaders_pkg::coord_x_t'(invaders_pkg::screen_w - 1);
				last_y = '0;
			end
			invaders_pkg::paint_sprite: begin
				last_x = invaders_pkg::coord_x_t'(invaders_pkg::sprite_w - 1);
				last_y = invaders_pkg::coord_y_t'(invaders_pkg::sprite_h - 1);
			end
			default: begin
				last_x = '0;
				last_y = '0;
			end
		endcase
	end

	assign paint_done = busy && off_x == last_x && off_y == last_y;

	always_ff @(posedge CLOCK_50) begin
		if (reset)
			busy <= 1'b0;
		else if (paint_start)
			busy <= 1'b1;
		else if (paint_done)
			busy <= 1'b0;
	end

	// raster walk, x fastest
	always_ff @(posedge CLOCK_50) begin
		if (paint_start) begin
			req <= paint_req;
			off_x <= '0;
			off_y <= '0;
		end else if (busy) begin
			if (off_x == last_x) begin
				off_x <= '0;
				off_y <= off_y + 1'b1;
			end else begin
				off_x <= off_x + 1'b1;
			end
		end
	end

	assign pixel.plot = busy;
	assign pixel.x = req.x + off_x;
	assign pixel.y = req.y + off_y;
	assign pixel.colour = req.colour;

	start_when_idle: assert property (@(posedge CLOCK_50) disable iff (reset)
		paint_start |-> !busy);

endmodule

`default_nettype wire

// ==== testbench/tb_space_invaders.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_space_invaders #(
	parameter int ALIEN_COUNT = 4
);

	localparam int frame_ticks = 2000;
	localparam int wait_limit = 40000;

	logic CLOCK_50;
	logic reset;
	invaders_pkg::buttons_t buttons;
	invaders_pkg::pixel_write_t pixel;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex4;
	logic [6:0] hex5;

	invaders_pkg::pixel_write_t writes[$];
	int errors;
	int tests;
	int seed;

	// reference model of cannon and fleet
	int cannon_x;
	int ax[4];
	int ay[4];
	logic mright[4];
	logic malive[4];

	space_invaders #(.FRAME_TICKS(frame_ticks), .ALIEN_COUNT(ALIEN_COUNT)) uut (
		.CLOCK_50(CLOCK_50), .reset(reset), .buttons(buttons), .pixel(pixel),
		.hex0(hex0), .hex1(hex1), .hex4(hex4), .hex5(hex5)
	);

	initial CLOCK_50 = 1'b0;
	always #2 CLOCK_50 = ~CLOCK_50;

	// pixel monitor, samples the previous cycle's write
	always @(posedge CLOCK_50) begin
		if (pixel.plot === 1'b1)
			writes.push_back(pixel);
	end

	task automatic fail_timeout(input string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic wrong(input string msg);
		errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	task automatic report(input string name, input int errors_before);
		tests++;
		if (errors == errors_before)
			$display("%s: ok", name);
		else
			$display("%s: failed", name);
	endtask

	function automatic logic [6:0] digit_segments(input int d);
		case (d)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			default: return 7'b0010000;
		endcase
	endfunction

	function automatic void move_alien(inout int x, inout int y, inout logic right);
		if (x >= 144) begin
			right = 1'b0;
			x = 143;
			y = y + 8;
		end else if (x == 0 && y != 0) begin
			right = 1'b1;
			x = 1;
			y = y + 8;
		end else if (right) begin
			x = x + 1;
		end else begin
			x = x - 1;
		end
	endfunction

	function automatic void init_model();
		cannon_x = 76;
		for (int i = 0; i < 4; i++) begin
			ax[i] = 30 * i;
			ay[i] = 0;
			mright[i] = 1'b1;
			malive[i] = (i < ALIEN_COUNT);
		end
	endfunction

	function automatic bit model_breach();
		bit b;
		b = 0;
		for (int i = 0; i < 4; i++) begin
			if (malive[i] && ay[i] + 7 >= 110)
				b = 1;
		end
		return b;
	endfunction

	// would a shot launched in the current frame hit something
	function automatic bit shot_hits(input int sx);
		int px[4];
		int py[4];
		logic pr[4];
		int sy;
		bit found;
		found = 0;
		for (int i = 0; i < 4; i++) begin
			px[i] = ax[i];
			py[i] = ay[i];
			pr[i] = mright[i];
		end
		for (int k = 0; k < 108 && !found; k++) begin
			if (k > 0) begin
				for (int i = 0; i < 4; i++) begin
					if (malive[i])
						move_alien(px[i], py[i], pr[i]);
				end
			end
			sy = 107 - k;
			for (int i = 0; i < 4; i++) begin
				if (malive[i] && sx >= px[i] && sx <= px[i] + 15 && sy >= py[i]
						&& sy <= py[i] + 7)
					found = 1;
			end
		end
		return found;
	endfunction

	task automatic pop_write(output invaders_pkg::pixel_write_t w);
		int waited;
		waited = 0;
		while (writes.size() == 0 && waited < wait_limit) begin
			@(negedge CLOCK_50);
			waited++;
		end
		if (writes.size() == 0)
			fail_timeout("a pixel write");
		else
			w = writes.pop_front();
	endtask

	// drop writes until one of the two colours is at the front
	task automatic skip_to(input invaders_pkg::colour_t a, input invaders_pkg::colour_t b,
			input int limit, output invaders_pkg::colour_t found);
		int waited;
		bit seen;
		invaders_pkg::pixel_write_t p;
		waited = 0;
		seen = 0;
		found = invaders_pkg::colour_black;
		while (!seen && waited < limit) begin
			if (writes.size() == 0) begin
				@(negedge CLOCK_50);
				waited++;
			end else if (writes[0].colour == a || writes[0].colour == b) begin
				found = writes[0].colour;
				seen = 1;
			end else begin
				p = writes.pop_front();
			end
		end
		if (!seen)
			fail_timeout("a coloured paint run");
	endtask

	task automatic check_run(input int x0, input int y0, input int w, input int h,
			input invaders_pkg::colour_t c, input string what);
		invaders_pkg::pixel_write_t p;
		int bad;
		string first;
		bad = 0;
		first = "";
		for (int yy = 0; yy < h; yy++) begin
			for (int xx = 0; xx < w; xx++) begin
				pop_write(p);
				if (p.x != 8'(x0 + xx) || p.y != 7'(y0 + yy) || p.colour != c) begin
					if (bad == 0)
						first = $sformatf(
							"%s expected (%0d,%0d) colour %0d, got (%0d,%0d) colour %0d",
							what, x0 + xx, y0 + yy, c, p.x, p.y, p.colour);
					bad++;
				end
			end
		end
		if (bad != 0)
			wrong($sformatf("%s, %0d wrong writes", first, bad));
	endtask

	task automatic check_displays(input int score, input int high);
		if (hex0 != digit_segments(score % 10) || hex1 != digit_segments(score / 10))
			wrong($sformatf("score display %b %b, expected %0d", hex1, hex0, score));
		if (hex4 != digit_segments(high % 10) || hex5 != digit_segments(high / 10))
			wrong($sformatf("high score display %b %b, expected %0d", hex5, hex4, high));
	endtask

	// one frame: find the cannon draw and advance the fleet model
	task automatic next_frame(output int x, output bit red);
		invaders_pkg::colour_t c;
		invaders_pkg::pixel_write_t p;
		x = -1;
		skip_to(invaders_pkg::colour_white, invaders_pkg::colour_red, wait_limit, c);
		red = (c == invaders_pkg::colour_red);
		if (!red) begin
			pop_write(p);
			x = p.x;
			if (p.y != 7'd110)
				wrong($sformatf("cannon drawn on row %0d", p.y));
			for (int i = 1; i < 128; i++)
				pop_write(p);
			for (int i = 0; i < 4; i++) begin
				if (malive[i])
					move_alien(ax[i], ay[i], mright[i]);
			end
		end
	endtask

	task automatic new_game_paint(input string name);
		int e0;
		e0 = errors;
		init_model();
		check_run(0, 0, 160, 120, invaders_pkg::colour_black, "screen clear");
		check_run(0, 108, 160, 1, invaders_pkg::colour_cyan, "end line");
		check_run(76, 110, 16, 8, invaders_pkg::colour_white, "cannon");
		report(name, e0);
	endtask

	task automatic displays_after_reset();
		int e0;
		e0 = errors;
		check_displays(0, 0);
		report("displays after reset", e0);
	endtask

	task automatic cannon_moves();
		int holds[5];
		logic go_right[5];
		int x;
		bit red;
		int e0;
		e0 = errors;
		holds[0] = 1 + (($random(seed) & 32'h7fffffff) % 12);
		holds[1] = 1 + (($random(seed) & 32'h7fffffff) % 12);
		holds[2] = 80;
		holds[3] = 160;
		holds[4] = 1 + (($random(seed) & 32'h7fffffff) % 12);
		go_right = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
		for (int h = 0; h < 5; h++) begin
			@(posedge CLOCK_50);
			#1;
			buttons.right = go_right[h];
			buttons.left = !go_right[h];
			for (int n = 0; n < holds[h]; n++) begin
				next_frame(x, red);
				if (red) begin
					wrong("red fill during cannon movement");
					return;
				end
				if (go_right[h] && cannon_x < 144)
					cannon_x++;
				else if (!go_right[h] && cannon_x > 0)
					cannon_x--;
				if (x != cannon_x)
					wrong($sformatf("cannon drawn at %0d, expected %0d", x, cannon_x));
				if (x < 0 || x > 144)
					wrong($sformatf("cannon drawn outside the limits at %0d", x));
			end
		end
		@(posedge CLOCK_50);
		#1;
		buttons.right = 1'b0;
		buttons.left = 1'b0;
		report("cannon movement", e0);
	endtask

	task automatic kill_and_win();
		int x;
		int frames;
		bit red;
		bit fired;
		invaders_pkg::colour_t c;
		int e0;
		e0 = errors;
		frames = 0;
		fired = 0;
		red = 0;
		while (!fired && !red && frames < 4000) begin
			next_frame(x, red);
			frames++;
			// the shot step of this frame is still ahead
			if (!red && shot_hits(cannon_x + 4)) begin
				@(posedge CLOCK_50);
				#1;
				buttons.fire = 1'b1;
				fired = 1;
			end
		end
		if (!fired) begin
			wrong("no launch frame found for the shot");
		end else begin
			skip_to(invaders_pkg::colour_green, invaders_pkg::colour_red, 300000, c);
			if (c != invaders_pkg::colour_green)
				wrong("red fill instead of green after the kill");
			check_run(0, 0, 160, 120, invaders_pkg::colour_green, "win fill");
			check_displays(1, 1);
		end
		@(posedge CLOCK_50);
		#1;
		buttons.fire = 1'b0;
		report("kill and win", e0);
	endtask

	task automatic breach_and_restart();
		int x;
		int frames;
		bit red;
		invaders_pkg::colour_t c;
		int e0;
		e0 = errors;
		frames = 0;
		red = 0;
		while (!red && !model_breach() && frames < 5000) begin
			next_frame(x, red);
			frames++;
		end
		if (red)
			wrong("red fill before the predicted breach frame");
		if (!model_breach())
			wrong("model never reached a breach");
		// the fill belongs to the breach frame, before any further cannon draw
		skip_to(invaders_pkg::colour_red, invaders_pkg::colour_white, wait_limit, c);
		if (c != invaders_pkg::colour_red)
			wrong("no red fill in the predicted breach frame");
		check_run(0, 0, 160, 120, invaders_pkg::colour_red, "lose fill");
		check_displays(0, 0);
		report("breach", e0);
		@(posedge CLOCK_50);
		#1;
		buttons.restart = 1'b1;
		@(posedge CLOCK_50);
		#1;
		buttons.restart = 1'b0;
		new_game_paint("new game after restart");
	endtask

	initial begin
		seed = 25088;
		errors = 0;
		tests = 0;
		buttons = '0;
		reset = 1'b1;
		init_model();
		repeat (16) @(posedge CLOCK_50);
		#1;
		reset = 1'b0;
		new_game_paint("new game painting");
		displays_after_reset();
		cannon_moves();
		if (ALIEN_COUNT == 1)
			kill_and_win();
		else
			breach_and_restart();
		$display("tests run %0d, failed checks %0d", tests, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
